//--- filelist.f
+incdir+design
design/fm_pkg.sv
design/fm_slot_regs.sv
design/fm_mmr.sv
design/fm_timers.sv
design/fm_ctrl_top.sv
bench/fm_ctrl_asserts.sv
bench/fm_ctrl_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --timing --assert --timescale 1ns/1ps
TOP       = fm_ctrl_tb
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || (echo "no result line in log"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/fm_ctrl_tb.sv
// Drives host writes into the FM control subsystem and checks slots, globals and timers
// Built from the file list as the simulation top
`timescale 1ns/1ps
`include "fm_settings.svh"

module fm_ctrl_tb;
	import fm_pkg::*;

	// About 150 writes at up to 35 cycles each, plus the timer waits
	localparam int MAX_CYCLES = 20000;
	localparam int TA_VALUE = 1000;
	localparam int TB_VALUE = 250;
	// Cycles from load to the first overflow of each timer
	localparam int TA_CYCLES = (1024 - TA_VALUE) * `FM_TIMER_A_DIV;
	localparam int TB_CYCLES = (256 - TB_VALUE) * `FM_TIMER_B_DIV;

	logic           clk;
	logic           rst;
	logic [7:0]     d_in;
	logic           a0;
	logic           write;
	logic           busy;
	fm_global_t     global_out;
	fm_slot_t       slot_out;
	fm_timer_stat_t timer_stat;

	// Reference model
	fm_ch_t     ch_m [8];
	fm_op_t     op_m [32];
	fm_global_t glob_m;
	logic [7:0] cur_addr;
	// Slots whose new value may not be visible while busy is high
	logic [31:0] skip_mask;
	int          lfo_rst_seen;
	int          lfo_rst_writes;
	int          cycles;

	fm_ctrl_top u_fm_ctrl_top (
		.clk        (clk),
		.rst        (rst),
		.d_in       (d_in),
		.a0         (a0),
		.write      (write),
		.busy       (busy),
		.global_out (global_out),
		.slot_out   (slot_out),
		.timer_stat (timer_stat)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#2 clk = ~clk;
		end
	end

	task stop_run(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task check_slot(input string name, input fm_slot_t exp, input fm_slot_t act);
		if (act !== exp) begin
			stop_run($sformatf("mismatch at time %0t: %s expected %h actual %h",
				$time, name, exp, act));
		end
	endtask

	task check_global(input string name, input fm_global_t exp, input fm_global_t act);
		if (act !== exp) begin
			stop_run($sformatf("mismatch at time %0t: %s expected %h actual %h",
				$time, name, exp, act));
		end
	endtask

	task check_timer(input string name, input fm_timer_stat_t exp, input fm_timer_stat_t act);
		if (act !== exp) begin
			stop_run($sformatf("mismatch at time %0t: %s expected %b actual %b",
				$time, name, exp, act));
		end
	endtask

	function automatic fm_slot_t fm_expect_slot(input logic [4:0] idx);
		fm_slot_t s;
		s.slot = idx;
		s.ch = ch_m[idx[4:2]];
		s.op = op_m[idx];
		return s;
	endfunction

	// Applies one data write to the model with fields laid out as in the chip register map
	task model_write(input logic [7:0] addr, input logic [7:0] d);
		logic [2:0] ch;
		logic [4:0] idx;
		ch = addr[2:0];
		idx = {addr[2:0], addr[4:3]};
		skip_mask = '0;
		if (addr == `FM_REG_KON) begin
			for (int i = 0; i < 4; i++) begin
				op_m[{d[2:0], 2'(i)}].keyon = d[3 + i];
			end
			skip_mask[{d[2:0], 2'b00} +: 4] = 4'hF;
		end else if (addr < `FM_CH_BASE) begin
			case (addr)
				`FM_REG_NOISE: begin
					glob_m.ne = d[7];
					glob_m.nfrq = d[4:0];
				end
				`FM_REG_LFRQ: begin
					glob_m.lfo_freq = d;
					lfo_rst_writes++;
				end
				`FM_REG_PMDAMD: begin
					if (d[7]) begin
						glob_m.lfo_pmd = d[6:0];
					end else begin
						glob_m.lfo_amd = d[6:0];
					end
				end
				`FM_REG_CTW: begin
					glob_m.ct2 = d[7];
					glob_m.ct1 = d[6];
					glob_m.lfo_w = d[1:0];
				end
				default: begin
					// Timer registers show up in the flags only
				end
			endcase
		end else if (addr < `FM_OP_BASE) begin
			case (addr[4:3])
				2'd0: begin
					ch_m[ch].rl = d[7:6];
					ch_m[ch].fb = d[5:3];
					ch_m[ch].con = d[2:0];
				end
				2'd1: ch_m[ch].kc = d[6:0];
				2'd2: ch_m[ch].kf = d[7:2];
				default: begin
					ch_m[ch].pms = d[6:4];
					ch_m[ch].ams = d[1:0];
				end
			endcase
			// The channel record shows on all four slots of the channel
			skip_mask[{ch, 2'b00} +: 4] = 4'hF;
		end else begin
			case (addr[7:5])
				3'd2: begin
					op_m[idx].dt1 = d[6:4];
					op_m[idx].mul = d[3:0];
				end
				3'd3: op_m[idx].tl = d[6:0];
				3'd4: begin
					op_m[idx].ks = d[7:6];
					op_m[idx].ar = d[4:0];
				end
				3'd5: begin
					op_m[idx].amsen = d[7];
					op_m[idx].d1r = d[4:0];
				end
				3'd6: begin
					op_m[idx].dt2 = d[7:6];
					op_m[idx].d2r = d[4:0];
				end
				default: begin
					op_m[idx].d1l = d[7:4];
					op_m[idx].rr = d[3:0];
				end
			endcase
			skip_mask[idx] = 1'b1;
		end
	endtask

	// One bus write that starts and ends on a falling edge with busy low
	task host_cycle(input logic sel_data, input logic [7:0] d, output int busy_cycles);
		int n;
		n = 0;
		if (busy) begin
			stop_run("busy still high when a new write started");
		end
		a0 = sel_data;
		d_in = d;
		write = 1'b1;
		@(posedge clk);
		// DUT takes the write on this edge
		if (sel_data) begin
			model_write(cur_addr, d);
		end else begin
			cur_addr = d;
		end
		@(negedge clk);
		write = 1'b0;
		if (!busy) begin
			stop_run("busy did not rise after an accepted write");
		end
		while (busy) begin
			@(negedge clk);
			n++;
			if (n > 40) begin
				stop_run("busy stuck high after a write");
			end
		end
		busy_cycles = n;
	endtask

	task reg_write(input logic [7:0] addr, input logic [7:0] d, output int data_busy);
		int n;
		host_cycle(1'b0, addr, n);
		if (n != 1) begin
			stop_run($sformatf("mismatch at time %0t: address busy cycles expected 1 actual %0d",
				$time, n));
		end
		host_cycle(1'b1, d, data_busy);
	endtask

	task slot_write(input logic [7:0] addr, input logic [7:0] d);
		int n;
		reg_write(addr, d, n);
		if (n < 2 || n > 33) begin
			stop_run($sformatf("slot write to %h took %0d busy cycles, outside 2 to 33", addr, n));
		end
	endtask

	task global_write(input logic [7:0] addr, input logic [7:0] d);
		int n;
		reg_write(addr, d, n);
		if (n != 1) begin
			stop_run($sformatf("mismatch at time %0t: busy cycles expected 1 actual %0d",
				$time, n));
		end
		check_global("global_out", glob_m, global_out);
		if (lfo_rst_seen != lfo_rst_writes) begin
			stop_run($sformatf("mismatch at time %0t: lfo_rst pulses expected %0d actual %0d",
				$time, lfo_rst_writes, lfo_rst_seen));
		end
	endtask

	// Flags checked against windows around the expected overflow
	task watch_timers();
		for (int k = 1; k <= TB_CYCLES + 6; k++) begin
			@(negedge clk);
			if (k < TA_CYCLES - 2 && timer_stat.flag_a) begin
				stop_run("timer A flag set too early");
			end
			if (k > TA_CYCLES + 4 && !timer_stat.flag_a) begin
				stop_run("timer A flag not set in time");
			end
			if (k < TB_CYCLES - 2 && timer_stat.flag_b) begin
				stop_run("timer B flag set too early");
			end
			if (k > TB_CYCLES + 4 && !timer_stat.flag_b) begin
				stop_run("timer B flag not set in time");
			end
			if (timer_stat.irq !== timer_stat.flag_a) begin
				stop_run($sformatf("mismatch at time %0t: irq expected %b actual %b",
					$time, timer_stat.flag_a, timer_stat.irq));
			end
		end
		check_timer("timer_stat", '{flag_a: 1'b1, flag_b: 1'b1, irq: 1'b1}, timer_stat);
	endtask

	initial begin : slot_compare
		logic [4:0] idx;
		idx = '0;
		lfo_rst_seen = 0;
		@(posedge clk);
		while (rst) begin
			@(posedge clk);
		end
		forever begin
			@(negedge clk);
			if (!(busy && skip_mask[idx])) begin
				check_slot("slot_out", fm_expect_slot(idx), slot_out);
			end
			if (global_out.lfo_rst) begin
				lfo_rst_seen++;
			end
			idx = idx + 5'd1;
		end
	end

	initial begin
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, the run did not finish", MAX_CYCLES);
		$display("RESULT: FAIL");
		$fatal(1, "timeout");
	end

	initial begin
		logic [7:0] data;
		void'($urandom(26));
		rst = 1'b1;
		d_in = '0;
		a0 = 1'b0;
		write = 1'b0;
		for (int i = 0; i < 8; i++) begin
			ch_m[i] = '0;
		end
		for (int i = 0; i < 32; i++) begin
			op_m[i] = '0;
		end
		glob_m = '0;
		cur_addr = '0;
		skip_mask = '0;
		lfo_rst_writes = 0;
		repeat (8) @(negedge clk);
		rst = 1'b0;

		// Reset state over a full scan
		repeat (40) @(negedge clk);
		if (busy) begin
			stop_run("busy high after reset");
		end
		check_timer("timer_stat", '{flag_a: 1'b0, flag_b: 1'b0, irq: 1'b0}, timer_stat);
		check_global("global_out", glob_m, global_out);

		// Random channel and operator writes
		for (int i = 0; i < 100; i++) begin
			data = 8'($urandom);
			slot_write(8'h20 + 8'($urandom % 224), data);
		end

		// Global registers with PMD and AMD both reached through bit 7
		for (int i = 0; i < 2; i++) begin
			global_write(`FM_REG_NOISE, 8'($urandom));
			global_write(`FM_REG_LFRQ, 8'($urandom));
			global_write(`FM_REG_PMDAMD, 8'($urandom) | 8'h80);
			global_write(`FM_REG_PMDAMD, 8'($urandom) & 8'h7F);
			global_write(`FM_REG_CTW, 8'($urandom));
		end

		// Key-on with random channel and operator mask
		for (int i = 0; i < 16; i++) begin
			data = {1'b0, 4'($urandom), 3'($urandom)};
			slot_write(`FM_REG_KON, data);
		end
		repeat (40) @(negedge clk);

		// Timers with irq enabled for A only
		global_write(`FM_REG_CLKA1, 8'(TA_VALUE >> 2));
		global_write(`FM_REG_CLKA2, 8'(TA_VALUE & 3));
		global_write(`FM_REG_CLKB, 8'(TB_VALUE));
		global_write(`FM_REG_TIMER, 8'h07);
		watch_timers();
		// Clear flag A and halt both timers so flag B stands alone without irq
		global_write(`FM_REG_TIMER, 8'h14);
		check_timer("timer_stat", '{flag_a: 1'b0, flag_b: 1'b1, irq: 1'b0}, timer_stat);
		// Clear both flags and halt both timers
		global_write(`FM_REG_TIMER, 8'h34);
		check_timer("timer_stat", '{flag_a: 1'b0, flag_b: 1'b0, irq: 1'b0}, timer_stat);
		repeat (200) @(negedge clk);
		check_timer("timer_stat", '{flag_a: 1'b0, flag_b: 1'b0, irq: 1'b0}, timer_stat);

		$display("RESULT: PASS");
		$finish;
	end

endmodule

//--- bench/fm_ctrl_asserts.sv
// Protocol checks on the register decoder
// Bound into every fm_mmr instance
`timescale 1ns/1ps

module fm_ctrl_asserts (
	input logic                  clk,
	input logic                  rst,
	input logic                  write,
	input logic                  busy,
	input logic                  pending,
	input fm_pkg::fm_timer_cfg_t timer_cfg
);

	logic [5:0] pulses;

	assign pulses = {timer_cfg.load_a, timer_cfg.load_b, timer_cfg.stop_a,
		timer_cfg.stop_b, timer_cfg.clr_flag_a, timer_cfg.clr_flag_b};

	// Accepted write raises busy on the next edge
	assert property (@(posedge clk) disable iff (rst) write && !busy |=> busy)
		else $error("busy did not rise after an accepted write");

	// Load, stop and clear strobes
	assert property (@(posedge clk) disable iff (rst) (pulses & $past(pulses)) == 6'b0)
		else $error("timer pulse held for more than one cycle");

	// Slot storage only starts waiting right after an accepted data write
	assert property (@(posedge clk) disable iff (rst) $rose(pending) |-> $past(busy))
		else $error("slot write pending without an accepted write");

endmodule

bind fm_mmr fm_ctrl_asserts u_asserts (
	.clk       (clk),
	.rst       (rst),
	.write     (write),
	.busy      (busy),
	.pending   (pending),
	.timer_cfg (timer_cfg)
);

//--- design/fm_ctrl_top.sv
// Top of the FM control subsystem
// Joins the host register decoder with the interval timers
`timescale 1ns/1ps

module fm_ctrl_top (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [7:0]             d_in,
	input  logic                   a0,
	input  logic                   write,
	output logic                   busy,
	output fm_pkg::fm_global_t     global_out,
	output fm_pkg::fm_slot_t       slot_out,
	output fm_pkg::fm_timer_stat_t timer_stat
);
	import fm_pkg::*;

	fm_timer_cfg_t timer_cfg;

	fm_mmr u_mmr (
		.clk        (clk),
		.rst        (rst),
		.d_in       (d_in),
		.a0         (a0),
		.write      (write),
		.busy       (busy),
		.global_out (global_out),
		.timer_cfg  (timer_cfg),
		.slot_out   (slot_out)
	);

	fm_timers u_timers (
		.clk  (clk),
		.rst  (rst),
		.cfg  (timer_cfg),
		.stat (timer_stat)
	);

endmodule

//--- design/fm_timers.sv
// Interval timers A and B with prescalers, overflow flags and irq
// Driven by the timer fields of the register decoder
`timescale 1ns/1ps
`include "fm_settings.svh"

module fm_timers (
	input  logic                   clk,
	input  logic                   rst,
	input  fm_pkg::fm_timer_cfg_t  cfg,
	output fm_pkg::fm_timer_stat_t stat
);

	logic [$clog2(`FM_TIMER_A_DIV)-1:0] presc_a;
	logic [$clog2(`FM_TIMER_B_DIV)-1:0] presc_b;
	logic [9:0]                         cnt_a;
	logic [7:0]                         cnt_b;
	logic                               run_a;
	logic                               run_b;
	logic                               flag_a;
	logic                               flag_b;
	logic                               tick_a;
	logic                               tick_b;
	logic                               ovf_a;
	logic                               ovf_b;

	// Prescalers wrap on their own, all ones ends a count period
	assign tick_a = run_a && &presc_a;
	assign tick_b = run_b && &presc_b;
	assign ovf_a = tick_a && &cnt_a;
	assign ovf_b = tick_b && &cnt_b;

	// Timer A, 10 bits
	always_ff @(posedge clk) begin
		if (rst) begin
			run_a <= 1'b0;
			presc_a <= '0;
			cnt_a <= '0;
			flag_a <= 1'b0;
		end else begin
			// Load only starts a halted timer
			if (cfg.load_a && !run_a) begin
				run_a <= 1'b1;
				presc_a <= '0;
				cnt_a <= cfg.value_a;
			end else if (cfg.stop_a) begin
				run_a <= 1'b0;
			end else if (run_a) begin
				presc_a <= presc_a + 1'b1;
				if (tick_a) begin
					cnt_a <= ovf_a ? cfg.value_a : cnt_a + 1'b1;
				end
			end
			if (cfg.clr_flag_a) begin
				flag_a <= 1'b0;
			end
			if (ovf_a) begin
				flag_a <= 1'b1;
			end
		end
	end

	// Timer B, 8 bits
	always_ff @(posedge clk) begin
		if (rst) begin
			run_b <= 1'b0;
			presc_b <= '0;
			cnt_b <= '0;
			flag_b <= 1'b0;
		end else begin
			if (cfg.load_b && !run_b) begin
				run_b <= 1'b1;
				presc_b <= '0;
				cnt_b <= cfg.value_b;
			end else if (cfg.stop_b) begin
				run_b <= 1'b0;
			end else if (run_b) begin
				presc_b <= presc_b + 1'b1;
				if (tick_b) begin
					cnt_b <= ovf_b ? cfg.value_b : cnt_b + 1'b1;
				end
			end
			if (cfg.clr_flag_b) begin
				flag_b <= 1'b0;
			end
			if (ovf_b) begin
				flag_b <= 1'b1;
			end
		end
	end

	assign stat = '{
		flag_a: flag_a,
		flag_b: flag_b,
		irq: (flag_a && cfg.irq_en_a) || (flag_b && cfg.irq_en_b)
	};

endmodule

//--- design/fm_mmr.sv
// Host write decoder and global registers of the FM control block
// Even writes select a register, odd writes store data, busy paces the host
`timescale 1ns/1ps
`include "fm_settings.svh"

module fm_mmr (
	input  logic                  clk,
	input  logic                  rst,
	input  logic [7:0]            d_in,
	input  logic                  a0,
	input  logic                  write,
	output logic                  busy,
	output fm_pkg::fm_global_t    global_out,
	output fm_pkg::fm_timer_cfg_t timer_cfg,
	output fm_pkg::fm_slot_t      slot_out
);
	import fm_pkg::*;

	logic [7:0]   sel_reg;
	fm_reg_data_u din_latch;
	logic         wr_busy;
	logic         upd;
	logic         pending;
	logic         accept;
	logic         is_global;

	assign accept = write && !busy;
	assign is_global = sel_reg < `FM_CH_BASE;

	// One cycle for every write, longer while a slot write waits for its turn
	assign busy = wr_busy | pending;

	always_ff @(posedge clk) begin
		if (rst) begin
			sel_reg <= '0;
			wr_busy <= 1'b0;
			upd <= 1'b0;
			global_out <= '0;
			timer_cfg <= '0;
		end else begin
			wr_busy <= accept;
			upd <= 1'b0;

			// Pulses drop after one cycle
			global_out.lfo_rst <= 1'b0;
			timer_cfg.load_a <= 1'b0;
			timer_cfg.load_b <= 1'b0;
			timer_cfg.stop_a <= 1'b0;
			timer_cfg.stop_b <= 1'b0;
			timer_cfg.clr_flag_a <= 1'b0;
			timer_cfg.clr_flag_b <= 1'b0;

			if (accept && !a0) begin
				sel_reg <= d_in;
			end

			if (accept && a0) begin
				if (is_global) begin
					case (sel_reg)
						// Key-on is stored per operator, so it goes to the slots
						`FM_REG_KON: upd <= 1'b1;
						`FM_REG_NOISE: begin
							global_out.ne <= d_in[7];
							global_out.nfrq <= d_in[4:0];
						end
						`FM_REG_CLKA1: timer_cfg.value_a[9:2] <= d_in;
						`FM_REG_CLKA2: timer_cfg.value_a[1:0] <= d_in[1:0];
						`FM_REG_CLKB: timer_cfg.value_b <= d_in;
						`FM_REG_TIMER: begin
							timer_cfg.clr_flag_b <= d_in[5];
							timer_cfg.clr_flag_a <= d_in[4];
							timer_cfg.irq_en_b <= d_in[3];
							timer_cfg.irq_en_a <= d_in[2];
							// A cleared load bit halts that timer
							timer_cfg.load_b <= d_in[1];
							timer_cfg.stop_b <= ~d_in[1];
							timer_cfg.load_a <= d_in[0];
							timer_cfg.stop_a <= ~d_in[0];
						end
						`FM_REG_LFRQ: begin
							global_out.lfo_freq <= d_in;
							// New rate restarts the LFO
							global_out.lfo_rst <= 1'b1;
						end
						`FM_REG_PMDAMD: begin
							// Bit 7 picks PM depth over AM depth
							if (d_in[7]) begin
								global_out.lfo_pmd <= d_in[6:0];
							end else begin
								global_out.lfo_amd <= d_in[6:0];
							end
						end
						`FM_REG_CTW: begin
							global_out.ct2 <= d_in[7];
							global_out.ct1 <= d_in[6];
							global_out.lfo_w <= d_in[1:0];
						end
						default: begin
							// Unmapped global address, write is dropped
						end
					endcase
				end else begin
					// Channel and operator groups
					upd <= 1'b1;
				end
			end
		end
	end

	// Data byte for the slot storage
	always_ff @(posedge clk) begin
		if (accept && a0) begin
			din_latch <= d_in;
		end
	end

	fm_slot_regs u_slot_regs (
		.clk      (clk),
		.rst      (rst),
		.upd      (upd),
		.addr     (sel_reg),
		.data     (din_latch),
		.pending  (pending),
		.slot_out (slot_out)
	);

endmodule

//--- design/fm_slot_regs.sv
// Channel and operator parameter storage scanned one slot per clock
// A write waits for its target slot, pending stays high until then
`timescale 1ns/1ps
`include "fm_settings.svh"

module fm_slot_regs (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 upd,
	input  logic [7:0]           addr,
	input  fm_pkg::fm_reg_data_u data,
	output logic                 pending,
	output fm_pkg::fm_slot_t     slot_out
);
	import fm_pkg::*;

	fm_ch_t       ch_mem [`FM_SLOTS/4];
	fm_op_t       op_mem [`FM_SLOTS];
	logic [4:0]   scan;
	logic [7:0]   pend_addr;
	fm_reg_data_u pend_data;
	logic         is_kon;
	logic         is_ch;
	logic [4:0]   target;
	logic         hit;
	fm_ch_t       ch_new;
	fm_op_t       op_new;
	fm_ch_t       ch_rd;
	fm_op_t       op_rd;

	assign is_kon = pend_addr == `FM_REG_KON;
	assign is_ch = pend_addr >= `FM_CH_BASE && pend_addr < `FM_OP_BASE;

	// Channel writes and key-on land on operator 0 of the channel
	always_comb begin
		if (is_kon) begin
			target = {pend_data.kon.ch, 2'b00};
		end else if (is_ch) begin
			target = {pend_addr[2:0], 2'b00};
		end else begin
			target = {pend_addr[2:0], pend_addr[4:3]};
		end
	end

	assign hit = pending && scan == target;

	// Target records with the pending byte merged in
	always_comb begin
		ch_new = ch_mem[target[4:2]];
		op_new = op_mem[target];
		if (is_kon) begin
			op_new.keyon = pend_data.kon.sn[0];
		end else if (is_ch) begin
			case (pend_addr[4:3])
				2'd0: begin
					ch_new.rl = pend_data.rl_fb_con.rl;
					ch_new.fb = pend_data.rl_fb_con.fb;
					ch_new.con = pend_data.rl_fb_con.con;
				end
				2'd1: ch_new.kc = pend_data.kc.kc;
				2'd2: ch_new.kf = pend_data.kf.kf;
				default: begin
					ch_new.pms = pend_data.pms_ams.pms;
					ch_new.ams = pend_data.pms_ams.ams;
				end
			endcase
		end else begin
			case (pend_addr[7:5])
				3'd2: begin
					op_new.dt1 = pend_data.dt1_mul.dt1;
					op_new.mul = pend_data.dt1_mul.mul;
				end
				3'd3: op_new.tl = pend_data.tl.tl;
				3'd4: begin
					op_new.ks = pend_data.ks_ar.ks;
					op_new.ar = pend_data.ks_ar.ar;
				end
				3'd5: begin
					op_new.amsen = pend_data.amsen_d1r.amsen;
					op_new.d1r = pend_data.amsen_d1r.d1r;
				end
				3'd6: begin
					op_new.dt2 = pend_data.dt2_d2r.dt2;
					op_new.d2r = pend_data.dt2_d2r.d2r;
				end
				default: begin
					op_new.d1l = pend_data.d1l_rr.d1l;
					op_new.rr = pend_data.d1l_rr.rr;
				end
			endcase
		end
	end

	// Scanned slot, bypassed so a finishing write shows at once
	always_comb begin
		ch_rd = ch_mem[scan[4:2]];
		op_rd = op_mem[scan];
		if (hit) begin
			ch_rd = ch_new;
			op_rd = op_new;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			scan <= '0;
			pending <= 1'b0;
			slot_out <= '0;
		end else begin
			scan <= scan + 1'b1;
			if (hit) begin
				pending <= 1'b0;
			end
			if (upd) begin
				pending <= 1'b1;
			end
			slot_out <= '{slot: scan, ch: ch_rd, op: op_rd};
		end
	end

	always_ff @(posedge clk) begin
		if (upd) begin
			pend_addr <= addr;
			pend_data <= data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `FM_SLOTS / 4; i++) begin
				ch_mem[i] <= '0;
			end
			for (int i = 0; i < `FM_SLOTS; i++) begin
				op_mem[i] <= '0;
			end
		end else if (hit) begin
			ch_mem[target[4:2]] <= ch_new;
			op_mem[target] <= op_new;
			// Key-on also rewrites the other three operators of the channel
			if (is_kon) begin
				for (int i = 1; i < 4; i++) begin
					op_mem[{target[4:2], 2'(i)}].keyon <= pend_data.kon.sn[i];
				end
			end
		end
	end

endmodule

//--- design/fm_pkg.sv
// Shared types of the FM control block
// Register byte views plus the channel, operator, global and timer records
package fm_pkg;

	// Data byte views, one per register group
	typedef struct packed {
		logic [1:0] rl;
		logic [2:0] fb;
		logic [2:0] con;
	} fm_view_rl_fb_con_t;

	typedef struct packed {
		logic       spare;
		logic [6:0] kc;
	} fm_view_kc_t;

	typedef struct packed {
		logic [5:0] kf;
		logic [1:0] spare;
	} fm_view_kf_t;

	typedef struct packed {
		logic       spare_hi;
		logic [2:0] pms;
		logic [1:0] spare_lo;
		logic [1:0] ams;
	} fm_view_pms_ams_t;

	typedef struct packed {
		logic       spare;
		logic [2:0] dt1;
		logic [3:0] mul;
	} fm_view_dt1_mul_t;

	typedef struct packed {
		logic       spare;
		logic [6:0] tl;
	} fm_view_tl_t;

	typedef struct packed {
		logic [1:0] ks;
		logic       spare;
		logic [4:0] ar;
	} fm_view_ks_ar_t;

	typedef struct packed {
		logic       amsen;
		logic [1:0] spare;
		logic [4:0] d1r;
	} fm_view_amsen_d1r_t;

	typedef struct packed {
		logic [1:0] dt2;
		logic       spare;
		logic [4:0] d2r;
	} fm_view_dt2_d2r_t;

	typedef struct packed {
		logic [3:0] d1l;
		logic [3:0] rr;
	} fm_view_d1l_rr_t;

	// Key-on byte, operator mask in 6:3 and channel in 2:0
	typedef struct packed {
		logic       spare;
		logic [3:0] sn;
		logic [2:0] ch;
	} fm_view_kon_t;

	// The same byte read through the view of its address group
	typedef union packed {
		fm_view_rl_fb_con_t rl_fb_con;
		fm_view_kc_t        kc;
		fm_view_kf_t        kf;
		fm_view_pms_ams_t   pms_ams;
		fm_view_dt1_mul_t   dt1_mul;
		fm_view_tl_t        tl;
		fm_view_ks_ar_t     ks_ar;
		fm_view_amsen_d1r_t amsen_d1r;
		fm_view_dt2_d2r_t   dt2_d2r;
		fm_view_d1l_rr_t    d1l_rr;
		fm_view_kon_t       kon;
	} fm_reg_data_u;

	typedef struct packed {
		logic [1:0] rl;
		logic [2:0] fb;
		logic [2:0] con;
		logic [6:0] kc;
		logic [5:0] kf;
		logic [2:0] pms;
		logic [1:0] ams;
	} fm_ch_t;

	typedef struct packed {
		logic [2:0] dt1;
		logic [3:0] mul;
		logic [6:0] tl;
		logic [1:0] ks;
		logic [4:0] ar;
		logic       amsen;
		logic [4:0] d1r;
		logic [1:0] dt2;
		logic [4:0] d2r;
		logic [3:0] d1l;
		logic [3:0] rr;
		logic       keyon;
	} fm_op_t;

	// Slot index is {channel, operator}
	typedef struct packed {
		logic [4:0] slot;
		fm_ch_t     ch;
		fm_op_t     op;
	} fm_slot_t;

	typedef struct packed {
		logic       ne;
		logic [4:0] nfrq;
		logic [7:0] lfo_freq;
		logic [1:0] lfo_w;
		logic [6:0] lfo_amd;
		logic [6:0] lfo_pmd;
		logic       ct1;
		logic       ct2;
		logic       lfo_rst;
	} fm_global_t;

	// Load, stop and clear are one-cycle pulses, the enables are levels
	typedef struct packed {
		logic [9:0] value_a;
		logic [7:0] value_b;
		logic       load_a;
		logic       load_b;
		logic       stop_a;
		logic       stop_b;
		logic       clr_flag_a;
		logic       clr_flag_b;
		logic       irq_en_a;
		logic       irq_en_b;
	} fm_timer_cfg_t;

	typedef struct packed {
		logic flag_a;
		logic flag_b;
		logic irq;
	} fm_timer_stat_t;

endpackage

//--- design/fm_settings.svh
// Register map, slot count and timer prescalers of the FM control block
// Included by every RTL file that decodes addresses or sizes storage
`ifndef FM_SETTINGS_SVH
`define FM_SETTINGS_SVH

// Key-on register, data picks channel and operator mask
`define FM_REG_KON     8'h08

// Noise enable and frequency
`define FM_REG_NOISE   8'h0F

// Timer A value, high eight bits then low two bits
`define FM_REG_CLKA1   8'h10
`define FM_REG_CLKA2   8'h11

// Timer B value
`define FM_REG_CLKB    8'h12

// Timer load, irq enable and flag clear
`define FM_REG_TIMER   8'h14

// LFO rate, depth and waveform
`define FM_REG_LFRQ    8'h18
`define FM_REG_PMDAMD  8'h19
`define FM_REG_CTW     8'h1B

// First channel and first operator address
`define FM_CH_BASE     8'h20
`define FM_OP_BASE     8'h40

// 8 channels times 4 operators
`define FM_SLOTS       32

// Clock cycles per timer count, powers of two
// Far below the real chip so simulation stays short
`define FM_TIMER_A_DIV 4
`define FM_TIMER_B_DIV 64

`endif
